//--- files.f
logic/convPkg.sv
logic/regFile2p.sv
logic/tapSequencer.sv
logic/macLane.sv
logic/resultDrain.sv
logic/convArray.sv
sim/convArray_asserts.sv
sim/convArray_tb.sv

//--- logic/convArray.sv
`timescale 1ns/1ns

module convArray (
    input  logic                              i_clk,
    input  logic                              i_arstN,
    input  logic                              i_wStrobe,
    input  logic [convPkg::LANE_W-1:0]        i_wLane,
    input  logic [convPkg::ADDR_W-1:0]        i_wAddr,
    input  logic signed [convPkg::DATA_W-1:0] i_wData,
    input  logic                              i_pixValid,
    input  logic signed [convPkg::DATA_W-1:0] i_pixel,
    input  logic                              i_start,
    output logic                              o_busy,
    output logic                              o_resValid,
    output logic [convPkg::LANE_W-1:0]        o_resLane,
    output logic signed [convPkg::ACC_W-1:0]  o_result
);

    import convPkg::*;

    logic [NUM_LANES-1:0]     wEn;
    logic [ADDR_W-1:0]        wAddr;
    logic signed [DATA_W-1:0] wData;
    logic [ADDR_W-1:0]        tapAddr;
    logic signed [DATA_W-1:0] tapPixel;
    logic                     tapValid;
    logic                     tapLast;
    logic                     draining;
    logic signed [ACC_W-1:0]  sum [NUM_LANES];
    logic [NUM_LANES-1:0]     sumValid;  // lanes run in lockstep

    tapSequencer feeder (
        .i_clk      (i_clk),
        .i_arstN    (i_arstN),
        .i_wStrobe  (i_wStrobe),
        .i_wLane    (i_wLane),
        .i_wAddr    (i_wAddr),
        .i_wData    (i_wData),
        .i_pixValid (i_pixValid),
        .i_pixel    (i_pixel),
        .i_start    (i_start),
        .i_draining (draining),
        .o_wEn      (wEn),
        .o_wAddr    (wAddr),
        .o_wData    (wData),
        .o_tapAddr  (tapAddr),
        .o_tapPixel (tapPixel),
        .o_tapValid (tapValid),
        .o_tapLast  (tapLast),
        .o_busy     (o_busy)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : genLane
        macLane lane (
            .i_clk      (i_clk),
            .i_arstN    (i_arstN),
            .i_wEn      (wEn[g]),
            .i_wAddr    (wAddr),
            .i_wData    (wData),
            .i_tapAddr  (tapAddr),
            .i_tapPixel (tapPixel),
            .i_tapValid (tapValid),
            .i_tapLast  (tapLast),
            .o_sum      (sum[g]),
            .o_sumValid (sumValid[g])
        );
    end

    resultDrain drain (
        .i_clk      (i_clk),
        .i_arstN    (i_arstN),
        .i_sum      (sum),
        .i_sumValid (sumValid[0]),
        .o_resValid (o_resValid),
        .o_resLane  (o_resLane),
        .o_result   (o_result),
        .o_draining (draining)
    );

endmodule

//--- logic/convPkg.sv
package convPkg;

    // lane count and lane index width
    localparam int NUM_LANES = 4;
    localparam int LANE_W    = $clog2(NUM_LANES);

    // one 3x3 kernel per lane
    localparam int KTAPS = 9;

    // register file depth, 12 words holds a 3x3 kernel with spare
    localparam int RF_WORDS = 12;
    localparam int ADDR_W   = $clog2(RF_WORDS);

    // weight and pixel width, both signed
    localparam int DATA_W = 8;

    // nine products of 8x8 signed fit in 19 bits
    localparam int ACC_W = 20;

endpackage

//--- logic/macLane.sv
`timescale 1ns/1ns

module macLane (
    input  logic                              i_clk,
    input  logic                              i_arstN,
    input  logic                              i_wEn,
    input  logic [convPkg::ADDR_W-1:0]        i_wAddr,
    input  logic signed [convPkg::DATA_W-1:0] i_wData,
    input  logic [convPkg::ADDR_W-1:0]        i_tapAddr,
    input  logic signed [convPkg::DATA_W-1:0] i_tapPixel,
    input  logic                              i_tapValid,
    input  logic                              i_tapLast,
    output logic signed [convPkg::ACC_W-1:0]  o_sum,
    output logic                              o_sumValid
);

    import convPkg::*;

    logic signed [DATA_W-1:0]   weight;
    logic signed [DATA_W-1:0]   pixD;    // pixel aligned with read data
    logic                       validD;
    logic                       lastD;
    logic                       firstD;
    logic signed [2*DATA_W-1:0] prod;
    logic signed [ACC_W-1:0]    accBase;
    logic signed [ACC_W-1:0]    acc;

    regFile2p #(
        .wordWd (RF_WORDS),
        .DWd    (DATA_W)
    ) weightRf (
        .i_clk   (i_clk),
        .i_arstN (i_arstN),
        .i_we    (i_wEn),
        .i_waddr (i_wAddr),
        .i_wdata (i_wData),
        .i_re    (i_tapValid),
        .i_raddr (i_tapAddr),
        .o_rdata (weight)
    );

    // one cycle delay to match the read latency
    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            validD     <= 1'b0;
            lastD      <= 1'b0;
            firstD     <= 1'b0;
            o_sumValid <= 1'b0;
        end else begin
            validD     <= i_tapValid;
            lastD      <= i_tapLast;
            firstD     <= i_tapValid && (i_tapAddr == '0);
            o_sumValid <= validD && lastD;
        end
    end

    always_ff @(posedge i_clk) begin
        pixD <= i_tapPixel;
    end

    assign prod = weight * pixD;

    always_comb begin
        if (firstD) begin
            accBase = '0;  // fresh run
        end else begin
            accBase = acc;
        end
    end

    always_ff @(posedge i_clk) begin
        if (validD) begin
            acc <= accBase + prod;
        end
    end

    assign o_sum = acc;

endmodule

//--- logic/regFile2p.sv
`timescale 1ns/1ns

module regFile2p #(
    parameter int wordWd = 12,
    parameter int DWd    = 32,
    localparam int AWd   = $clog2(wordWd)
) (
    input  logic           i_clk,
    input  logic           i_arstN,
    input  logic           i_we,
    input  logic [AWd-1:0] i_waddr,
    input  logic [DWd-1:0] i_wdata,
    input  logic           i_re,
    input  logic [AWd-1:0] i_raddr,
    output logic [DWd-1:0] o_rdata
);

    logic [DWd-1:0] mem [wordWd];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // registered read, old word on same-address write
    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_rdata <= '0;
        end else if (i_re) begin
            o_rdata <= mem[i_raddr];
        end
    end

endmodule

//--- logic/resultDrain.sv
`timescale 1ns/1ns

module resultDrain (
    input  logic                             i_clk,
    input  logic                             i_arstN,
    input  logic signed [convPkg::ACC_W-1:0] i_sum [convPkg::NUM_LANES],
    input  logic                             i_sumValid,
    output logic                             o_resValid,
    output logic [convPkg::LANE_W-1:0]       o_resLane,
    output logic signed [convPkg::ACC_W-1:0] o_result,
    output logic                             o_draining
);

    import convPkg::*;

    logic signed [ACC_W-1:0] hold [NUM_LANES];  // head of the shift is lane being sent
    logic                    active;
    logic [LANE_W-1:0]       laneCnt;
    logic                    lastLane;

    assign lastLane = (laneCnt == LANE_W'(NUM_LANES - 1));

    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            active  <= 1'b0;
            laneCnt <= '0;
        end else begin
            if (i_sumValid) begin
                active  <= 1'b1;
                laneCnt <= '0;
            end else if (active) begin
                if (lastLane) begin
                    active <= 1'b0;
                end
                laneCnt <= laneCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_sumValid) begin
            hold <= i_sum;
        end else if (active) begin
            for (int i = 0; i < NUM_LANES - 1; i++) begin
                hold[i] <= hold[i + 1];
            end
        end
    end

    assign o_resValid = active;
    assign o_draining = active;  // feeder keeps busy high
    assign o_resLane  = laneCnt;
    assign o_result   = hold[0];

endmodule

//--- logic/tapSequencer.sv
`timescale 1ns/1ns

module tapSequencer (
    input  logic                              i_clk,
    input  logic                              i_arstN,
    input  logic                              i_wStrobe,
    input  logic [convPkg::LANE_W-1:0]        i_wLane,
    input  logic [convPkg::ADDR_W-1:0]        i_wAddr,
    input  logic signed [convPkg::DATA_W-1:0] i_wData,
    input  logic                              i_pixValid,
    input  logic signed [convPkg::DATA_W-1:0] i_pixel,
    input  logic                              i_start,
    input  logic                              i_draining,
    output logic [convPkg::NUM_LANES-1:0]     o_wEn,
    output logic [convPkg::ADDR_W-1:0]        o_wAddr,
    output logic signed [convPkg::DATA_W-1:0] o_wData,
    output logic [convPkg::ADDR_W-1:0]        o_tapAddr,
    output logic signed [convPkg::DATA_W-1:0] o_tapPixel,
    output logic                              o_tapValid,
    output logic                              o_tapLast,
    output logic                              o_busy
);

    import convPkg::*;

    logic signed [DATA_W-1:0] window [KTAPS];  // index 0 is the oldest pixel
    logic                     running;         // start seen, drain not yet begun
    logic                     startOk;

    assign startOk    = i_start && !o_busy;  // starts while busy are dropped
    assign o_busy     = running || i_draining;
    assign o_tapLast  = o_tapValid && (o_tapAddr == ADDR_W'(KTAPS - 1));
    assign o_tapPixel = window[o_tapAddr];

    // lane decode of the weight write
    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_wEn <= '0;
        end else begin
            for (int l = 0; l < NUM_LANES; l++) begin
                o_wEn[l] <= i_wStrobe && (i_wLane == LANE_W'(l));
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_wStrobe) begin
            o_wAddr <= i_wAddr;
            o_wData <= i_wData;
        end
    end

    // newest pixel lands in tap 8
    always_ff @(posedge i_clk) begin
        if (i_pixValid) begin
            for (int k = 0; k < KTAPS - 1; k++) begin
                window[k] <= window[k + 1];
            end
            window[KTAPS - 1] <= i_pixel;
        end
    end

    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            running    <= 1'b0;
            o_tapValid <= 1'b0;
            o_tapAddr  <= '0;
        end else begin
            if (startOk) begin
                running    <= 1'b1;
                o_tapValid <= 1'b1;
                o_tapAddr  <= '0;
            end else if (o_tapValid) begin
                if (o_tapLast) begin
                    o_tapValid <= 1'b0;
                end else begin
                    o_tapAddr <= o_tapAddr + 1'b1;
                end
            end
            // drain takes over the busy level
            if (i_draining) begin
                running <= 1'b0;
            end
        end
    end

endmodule

//--- sim/convArray_asserts.sv
`timescale 1ns/1ns

module convArray_asserts (
    input logic                       i_clk,
    input logic                       i_arstN,
    input logic                       i_busy,
    input logic                       i_resValid,
    input logic [convPkg::LANE_W-1:0] i_resLane
);

    import convPkg::*;

    // busy ends only once the last lane has left the drain
    busyEnd: assert property (
        @(posedge i_clk) disable iff (!i_arstN)
        $fell(i_busy) |-> $past(i_resValid) && $past(i_resLane) == LANE_W'(NUM_LANES - 1)
    ) else $error("o_busy fell before the last lane result");

    // drain walks the lanes in ascending order
    laneStep: assert property (
        @(posedge i_clk) disable iff (!i_arstN)
        i_resValid && $past(i_resValid) |-> i_resLane == LANE_W'($past(i_resLane) + 1'b1)
    ) else $error("o_resLane did not step by one between results");

    resetQuiet: assert property (
        @(posedge i_clk)
        !i_arstN |-> !i_resValid && !i_busy
    ) else $error("outputs active during reset");

endmodule

bind convArray convArray_asserts checks (
    .i_clk      (i_clk),
    .i_arstN    (i_arstN),
    .i_busy     (o_busy),
    .i_resValid (o_resValid),
    .i_resLane  (o_resLane)
);

//--- sim/convArray_tb.sv
`timescale 1ns/1ns

module convArray_tb;

    import convPkg::*;

    typedef logic signed [DATA_W-1:0] byteArr [KTAPS];

    logic                     clk;
    logic                     arstN;
    logic                     wStrobe;
    logic [LANE_W-1:0]        wLane;
    logic [ADDR_W-1:0]        wAddr;
    logic signed [DATA_W-1:0] wData;
    logic                     pixValid;
    logic signed [DATA_W-1:0] pixel;
    logic                     start;
    logic                     busy;
    logic                     resValid;
    logic [LANE_W-1:0]        resLane;
    logic signed [ACC_W-1:0]  result;

    integer                  seed;
    int                      resCount;
    int                      runCount;
    byteArr                  wModel [NUM_LANES];  // mirror of each lane's weights
    byteArr                  pixModel;            // index 8 is the newest pixel
    logic [LANE_W-1:0]       expLane [$];
    logic signed [ACC_W-1:0] expRes [$];

    convArray UUT (
        .i_clk      (clk),
        .i_arstN    (arstN),
        .i_wStrobe  (wStrobe),
        .i_wLane    (wLane),
        .i_wAddr    (wAddr),
        .i_wData    (wData),
        .i_pixValid (pixValid),
        .i_pixel    (pixel),
        .i_start    (start),
        .o_busy     (busy),
        .o_resValid (resValid),
        .o_resLane  (resLane),
        .o_result   (result)
    );

    always #2 clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(input string name, input logic [ACC_W-1:0] got,
                              input logic [ACC_W-1:0] exp);
        if (got !== exp) begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            $display("Done: errors found");
            $fatal(1, "simulation stopped");
        end
    endtask

    // signed dot product of one kernel with the window
    function automatic logic signed [ACC_W-1:0] convRef(input byteArr w, input byteArr p);
        int total;
        total = 0;
        for (int k = 0; k < KTAPS; k++) begin
            total += int'(w[k]) * int'(p[k]);
        end
        return ACC_W'(total);
    endfunction

    function automatic logic signed [DATA_W-1:0] randByte();
        return DATA_W'($random(seed));
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic writeWeight(input int lane, input int addr, input logic signed [DATA_W-1:0] d);
        wStrobe = 1'b1;
        wLane   = LANE_W'(lane);
        wAddr   = ADDR_W'(addr);
        wData   = d;
        tick();
        wStrobe = 1'b0;
        wModel[lane][addr] = d;
    endtask

    task automatic loadKernel(input int lane, input byteArr k);
        for (int i = 0; i < KTAPS; i++) begin
            writeWeight(lane, i, k[i]);
        end
    endtask

    task automatic pushPixel(input logic signed [DATA_W-1:0] p);
        pixValid = 1'b1;
        pixel    = p;
        tick();
        pixValid = 1'b0;
        for (int k = 0; k < KTAPS - 1; k++) begin
            pixModel[k] = pixModel[k + 1];
        end
        pixModel[KTAPS - 1] = p;
    endtask

    task automatic loadWindow(input byteArr p);
        for (int k = 0; k < KTAPS; k++) begin
            pushPixel(p[k]);
        end
    endtask

    task automatic waitResults(input int target);
        int cycles;
        cycles = 0;
        while (resCount < target) begin
            tick();
            cycles++;
            if (cycles > 40) begin
                abortRun("timeout while waiting for lane results");
            end
        end
    endtask

    task automatic waitIdle();
        int cycles;
        cycles = 0;
        while (busy) begin
            tick();
            cycles++;
            if (cycles > 40) begin
                abortRun("timeout while waiting for the engine to go idle");
            end
        end
    endtask

    // secondAt > 0 sends an extra start that many cycles after the first
    task automatic runConv(input int secondAt);
        int target;
        target = resCount + NUM_LANES;
        for (int l = 0; l < NUM_LANES; l++) begin
            expLane.push_back(LANE_W'(l));
            expRes.push_back(convRef(wModel[l], pixModel));
        end
        runCount++;
        start = 1'b1;
        tick();
        start = 1'b0;
        if (secondAt > 0) begin
            repeat (secondAt - 1) tick();
            checkValue("o_busy", busy, 1'b1);
            start = 1'b1;
            tick();
            start = 1'b0;
        end
        waitResults(target);
        waitIdle();
    endtask

    // compare process, outputs settle well before the falling edge
    always @(negedge clk) begin
        if (arstN && resValid) begin
            if (expRes.size() == 0) begin
                abortRun("a result appeared with no run pending");
            end else begin
                checkValue("o_resLane", resLane, expLane.pop_front());
                checkValue("o_result", result, expRes.pop_front());
                resCount++;
            end
        end
    end

    initial begin
        byteArr kernel;
        byteArr win;
        int     mixW [NUM_LANES];
        seed     = 94289;
        clk      = 1'b0;
        arstN    = 1'b0;
        wStrobe  = 1'b0;
        wLane    = '0;
        wAddr    = '0;
        wData    = '0;
        pixValid = 1'b0;
        pixel    = '0;
        start    = 1'b0;
        resCount = 0;
        runCount = 0;
        repeat (8) @(posedge clk);
        #1;
        arstN = 1'b1;
        checkValue("o_busy", busy, 1'b0);
        checkValue("o_resValid", resValid, 1'b0);
        tick();

        // same kernel in every lane
        for (int k = 0; k < KTAPS; k++) begin
            kernel[k] = randByte();
            win[k]    = randByte();
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            loadKernel(l, kernel);
        end
        loadWindow(win);
        runConv(0);

        for (int l = 0; l < NUM_LANES; l++) begin
            for (int k = 0; k < KTAPS; k++) begin
                kernel[k] = randByte();
            end
            loadKernel(l, kernel);
        end
        runConv(0);  // window unchanged

        // signed extremes
        for (int k = 0; k < KTAPS; k++) begin
            kernel[k] = -8'sd128;
            win[k]    = -8'sd128;
        end
        checkValue("reference sum", convRef(kernel, win), 147456);
        for (int l = 0; l < NUM_LANES; l++) begin
            loadKernel(l, kernel);
        end
        loadWindow(win);
        runConv(0);
        mixW = '{127, -128, 1, -1};
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int k = 0; k < KTAPS; k++) begin
                kernel[k] = DATA_W'(mixW[l]);
            end
            loadKernel(l, kernel);
        end
        runConv(0);

        // extra starts during taps and during drain
        for (int k = 0; k < KTAPS; k++) begin
            pushPixel(randByte());
        end
        runConv(5);
        runConv(14);
        repeat (20) tick();  // a stray result from a dropped start shows up here

        // reload a whole lane, then a single word
        for (int k = 0; k < KTAPS; k++) begin
            kernel[k] = randByte();
        end
        loadKernel(2, kernel);
        runConv(0);
        writeWeight(1, 4, wModel[1][4] ^ 8'sh5a);
        runConv(0);

        for (int r = 0; r < 20; r++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                for (int k = 0; k < KTAPS; k++) begin
                    kernel[k] = randByte();
                end
                loadKernel(l, kernel);
            end
            for (int k = 0; k < KTAPS; k++) begin
                pushPixel(randByte());
            end
            runConv(0);
        end

        if (resCount == runCount * NUM_LANES && expRes.size() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
